//--- all.f
+incdir+.
decode_pkg.sv
fetch_skid_buffer.sv
rv_slot_decoder.sv
branch_check.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module tb_decode_stage -o vsim
	./obj_dir/vsim | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module tb_decode_stage;
    import decode_pkg::*;

    localparam int NUM = 14;

    typedef struct packed {
        logic [4:0]  alu_type;
        logic [4:0]  ios_type;
        logic [3:0]  special;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [2:0]  props;
        logic        ev;
        logic [3:0]  ec;
    } exp_slot_t;

    logic                   cpu_clk_i = 1'b0;
    logic                   arst_n_i;
    logic                   flush_i, priv_m_i, tw_i, icache_idle_i, icache_valid_i;
    fetch_bundle_t          fetch_i;
    logic                   busy_o, rn_busy_i;
    dec_uop_t               ins0_o, ins1_o;
    logic                   ins1_valid_o, valid_o, branch_correction_flush_o;
    logic [`DEC_PC_W-1:0]   pc_o, branch_correction_pc_o;
    btb_pred_t              btb_o;

    // stimulus table
    logic [63:0]            t_instr [NUM];
    logic [`DEC_PC_W-1:0]   t_pc [NUM];
    btb_pred_t              t_btb [NUM];
    logic                   t_priv [NUM], t_tw [NUM], t_fev [NUM], t_ins1v [NUM], t_corr [NUM];
    logic [3:0]             t_fec [NUM];
    exp_slot_t              t_exp0 [NUM], t_exp1 [NUM];
    int                     n_entries = 0;
    int                     n_corr = 0;
    int                     flush_count = 0;
    int                     exp_q [$];
    logic [`DEC_PC_W-1:0]   corr_pc = '0;
    logic [31:0]            lfsr = 32'h5e9adf87;

    decode_stage uut (.*);

    always #5 cpu_clk_i = ~cpu_clk_i;

    initial begin
        #((16 + 40 * NUM) * 10);
        $display("watchdog expired before all bundles were seen");
        $display("*** FAILED ***");
        $fatal(1);
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic exp_slot_t mk(input logic [4:0] alu, input logic [4:0] ios,
                                     input logic [3:0] spc, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [4:0] rd,
                                     input logic [31:0] imm, input logic [2:0] props,
                                     input logic ev, input logic [3:0] ec);
        return '{alu, ios, spc, rs1, rs2, rd, imm, props, ev, ec};
    endfunction

    function automatic btb_pred_t mk_btb(input logic vld, input logic idx,
                                         input logic [1:0] btype, input logic [1:0] bm,
                                         input logic [`DEC_PC_W-1:0] target);
        btb_pred_t b;
        b.btype = btype;
        b.bm_pred = bm;
        b.target = target;
        b.vld = vld;
        b.idx = idx;
        b.way = 1'b0;
        return b;
    endfunction

    task automatic add(input logic [31:0] lo, input logic [31:0] hi,
                       input logic [`DEC_PC_W-1:0] pc, input btb_pred_t btb,
                       input logic priv, input logic tw, input logic fev, input logic [3:0] fec,
                       input exp_slot_t e0, input exp_slot_t e1, input logic ins1v,
                       input logic corr);
        t_instr[n_entries] = {hi, lo};
        t_pc[n_entries] = pc;
        t_btb[n_entries] = btb;
        t_priv[n_entries] = priv;
        t_tw[n_entries] = tw;
        t_fev[n_entries] = fev;
        t_fec[n_entries] = fec;
        t_exp0[n_entries] = e0;
        t_exp1[n_entries] = e1;
        t_ins1v[n_entries] = ins1v;
        t_corr[n_entries] = corr;
        n_entries++;
    endtask

    task automatic build_table();
        btb_pred_t none;
        exp_slot_t addi_e, sub_e, ecall_e;
        none = mk_btb(0, 0, 2'b00, 2'b00, '0);
        addi_e = mk(5'b00001, 0, 0, 2, 27, 1, 32'hFFFFFFFB, 3'b110, 0, 0);  // addi x1,x2,-5
        sub_e = mk(5'b00001, 0, 0, 4, 5, 3, 32'h0, 3'b111, 0, 0);           // sub x3,x4,x5
        ecall_e = mk(0, 0, 0, 0, 0, 0, 32'h0, 3'b000, 1, 4'd8);
        add(32'hFFB10093, 32'h405201B3, 30'h100, none, 0, 0, 0, 0, addi_e, sub_e, 1, 0);
        add(32'h0083A303, 32'hFE942E23, 30'h102, none, 0, 0, 0, 0,          // lw / sw
            mk(0, 5'b10000, 0, 7, 8, 6, 32'h8, 3'b110, 0, 0),
            mk(0, 5'b01000, 0, 8, 9, 28, 32'hFFFFFFFC, 3'b011, 0, 0), 1, 0);
        add(32'h12345537, 32'h00001597, 30'h104, none, 0, 0, 0, 0,          // lui / auipc
            mk(5'b01000, 0, 0, 8, 3, 10, 32'h12345000, 3'b100, 0, 0),
            mk(5'b10000, 0, 0, 0, 0, 11, 32'h1000, 3'b100, 0, 0), 1, 0);
        add(32'h010000EF, 32'hFE208CE3, 30'h106, mk_btb(1, 1, 2'b00, 2'b11, 30'h102), 0, 0, 0,
            0, mk(5'b00010, 0, 0, 0, 16, 1, 32'd16, 3'b100, 0, 0),
            mk(0, 0, 0, 1, 2, 25, 32'hFFFFFFF8, 3'b011, 0, 0), 1, 0);
        add(32'hFFFFFFFF, 32'h00100293, 30'h109, none, 0, 0, 0, 0,          // odd pc
            mk(5'b00001, 0, 0, 0, 1, 5, 32'h1, 3'b110, 0, 0), addi_e, 0, 0);
        add(32'h0400006F, 32'hFFB10093, 30'h10A, mk_btb(1, 0, 2'b10, 2'b00, 30'h11A), 0, 0, 0,
            0, mk(5'b00010, 0, 0, 0, 0, 0, 32'd64, 3'b000, 0, 0), addi_e, 0, 0);
        add(32'h00000073, 32'h00100073, 30'h10C, none, 0, 0, 0, 0, ecall_e,
            mk(0, 0, 0, 0, 1, 0, 32'h1, 3'b000, 1, 4'd3), 1, 0);
        add(32'h00000073, 32'h30200073, 30'h10E, none, 1, 0, 0, 0,          // ecall / mret in M
            mk(0, 0, 0, 0, 0, 0, 32'h0, 3'b000, 1, 4'd11),
            mk(0, 0, 4'b0100, 0, 2, 0, 32'h302, 3'b000, 0, 0), 1, 0);
        add(32'h30200073, 32'h10500073, 30'h110, none, 0, 1, 0, 0,          // mret / wfi in U
            mk(0, 0, 4'b0100, 0, 2, 0, 32'h302, 3'b000, 1, 4'd2),
            mk(0, 0, 4'b0001, 0, 5, 0, 32'h105, 3'b000, 1, 4'd2), 1, 0);
        add(32'h0083E303, 32'h300110F3, 30'h112, none, 1, 0, 0, 0,          // bad load / csrrw
            mk(0, 5'b10000, 0, 7, 8, 6, 32'h8, 3'b110, 1, 4'd2),
            mk(0, 5'b00100, 4'b1000, 2, 0, 1, 32'h300, 3'b110, 0, 0), 1, 0);
        add(32'h00000073, 32'hFFFFFFFF, 30'h114, none, 0, 0, 1, 4'd1,       // fetch fault wins
            mk(0, 0, 0, 0, 0, 0, 32'h0, 3'b000, 1, 4'd1),
            mk(0, 0, 0, 31, 31, 31, 32'h0, 3'b010, 1, 4'd1), 1, 0);
        add(32'hFFB10093, 32'h405201B3, 30'h116, mk_btb(1, 0, 2'b00, 2'b00, 30'h120), 0, 0, 0,
            0, addi_e, sub_e, 1, 1);                                        // false prediction
        add(32'hFFB10093, 32'h405201B3, 30'h118, none, 0, 0, 0, 0, addi_e, sub_e, 1, 0);
        add(32'h0000100F, 32'h004280E7, 30'h11A, none, 0, 0, 0, 0,          // fence.i / jalr
            mk(0, 0, 4'b0010, 0, 0, 0, 32'h0, 3'b010, 0, 0),
            mk(5'b00100, 0, 0, 5, 4, 1, 32'h4, 3'b110, 0, 0), 1, 0);
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_slot(input string tag, input dec_uop_t u, input exp_slot_t e);
        compare({tag, ".alu_type"}, 64'(u.alu.alu_type), 64'(e.alu_type));
        compare({tag, ".ios_type"}, 64'(u.ios.ios_type), 64'(e.ios_type));
        compare({tag, ".special"}, 64'(u.special), 64'(e.special));
        compare({tag, ".rs1"}, 64'(u.rs1), 64'(e.rs1));
        compare({tag, ".rs2"}, 64'(u.rs2), 64'(e.rs2));
        compare({tag, ".dest"}, 64'(u.dest), 64'(e.dest));
        compare({tag, ".imm"}, 64'(u.imm), 64'(e.imm));
        compare({tag, ".reg_props"}, 64'(u.reg_props), 64'(e.props));
        compare({tag, ".excp_valid"}, 64'(u.excp_valid), 64'(e.ev));
        if (e.ev) begin
            compare({tag, ".excp_code"}, 64'(u.excp_code), 64'(e.ec));
        end
    endtask

    // one cycle at the falling edge: consume the output, then pick the next stall
    task automatic tick();
        logic stall;
        int   idx;
        lfsr = lfsr_step(lfsr);
        stall = lfsr[0];
        if (valid_o && !stall) begin
            if (exp_q.size() == 0) begin
                stop_run("valid_o was high with no bundle outstanding");
            end else begin
                idx = exp_q.pop_front();
                compare("pc_o", 64'(pc_o), 64'(t_pc[idx]));
                compare("btb_o", 64'(btb_o), 64'(t_btb[idx]));
                compare("ins1_valid_o", 64'(ins1_valid_o), 64'(t_ins1v[idx]));
                check_slot("ins0", ins0_o, t_exp0[idx]);
                if (t_ins1v[idx]) begin
                    check_slot("ins1", ins1_o, t_exp1[idx]);
                end
            end
        end
        rn_busy_i = stall;
        #1;
        if (branch_correction_flush_o) begin
            flush_count++;
            compare("branch_correction_pc_o", 64'(branch_correction_pc_o), 64'(corr_pc));
        end
    endtask

    task automatic send_entry(input int i);
        fetch_bundle_t b;
        logic          accepted;
        int            wait_cnt;
        while (busy_o) begin                 // skid entry must leave before priv changes
            @(negedge cpu_clk_i);
            tick();
        end
        priv_m_i = t_priv[i];
        tw_i = t_tw[i];
        b.instr = t_instr[i];
        b.pc = t_pc[i];
        b.btb = t_btb[i];
        b.excp_vld = t_fev[i];
        b.excp_code = t_fec[i];
        fetch_i = b;
        icache_valid_i = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = !busy_o;
            if (accepted && !t_corr[i]) begin
                exp_q.push_back(i);          // taken at the coming edge
            end
            @(negedge cpu_clk_i);
            tick();
        end
        icache_valid_i = 1'b0;
        if (t_corr[i]) begin
            corr_pc = t_pc[i];
            n_corr++;
            wait_cnt = 0;
            while (flush_count < n_corr) begin
                icache_idle_i = (wait_cnt >= 3);
                wait_cnt++;
                @(negedge cpu_clk_i);
                tick();
            end
            @(negedge cpu_clk_i);            // cache stays idle through the flush edge
            tick();
            icache_idle_i = 1'b0;
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        priv_m_i = 1'b0;
        tw_i = 1'b0;
        icache_idle_i = 1'b0;
        icache_valid_i = 1'b0;
        fetch_i = '0;
        rn_busy_i = 1'b0;
        build_table();
        repeat (16) @(posedge cpu_clk_i);
        @(negedge cpu_clk_i);
        compare("valid_o", 64'(valid_o), 64'd0);
        compare("busy_o", 64'(busy_o), 64'd0);
        compare("branch_correction_flush_o", 64'(branch_correction_flush_o), 64'd0);
        arst_n_i = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            send_entry(i);
        end
        while (exp_q.size() != 0) begin
            @(negedge cpu_clk_i);
            tick();
        end
        if (flush_count != n_corr) begin
            stop_run("number of correction flush pulses does not match the table");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module decode_stage_assert (
    input  wire logic                       cpu_clk_i,
    input  wire logic                       arst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       rn_busy_i,
    input  wire logic                       valid_o,
    input  wire logic                       busy_o,
    input  wire logic                       branch_correction_flush_o,
    input  wire decode_pkg::dec_uop_t       ins0_o,
    input  wire decode_pkg::dec_uop_t       ins1_o,
    input  wire logic [`DEC_PC_W-1:0]       pc_o
);
    // either flush empties the output register and the skid entry
    flush_clears: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        (flush_i || branch_correction_flush_o) |=> (!valid_o && !busy_o))
        else $error("valid_o or busy_o still set after a flush");

    hold_stable: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        (rn_busy_i && valid_o) |=> ($stable(pc_o) && $stable(ins0_o) && $stable(ins1_o)))
        else $error("output bundle changed under back-pressure");

    reset_vals: assert property (@(posedge cpu_clk_i)
        !arst_n_i |-> (!valid_o && !busy_o && !branch_correction_flush_o))
        else $error("outputs not cleared in reset");

endmodule

bind decode_stage decode_stage_assert u_assert (
    .cpu_clk_i                 (cpu_clk_i),
    .arst_n_i                  (arst_n_i),
    .flush_i                   (flush_i),
    .rn_busy_i                 (rn_busy_i),
    .valid_o                   (valid_o),
    .busy_o                    (busy_o),
    .branch_correction_flush_o (branch_correction_flush_o),
    .ins0_o                    (ins0_o),
    .ins1_o                    (ins1_o),
    .pc_o                      (pc_o)
);

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module decode_stage (
    input  wire logic                       cpu_clk_i,
    input  wire logic                       arst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       priv_m_i,
    input  wire logic                       tw_i,
    input  wire logic                       icache_idle_i,
    input  wire logic                       icache_valid_i,
    input  wire decode_pkg::fetch_bundle_t  fetch_i,
    output logic                            busy_o,
    input  wire logic                       rn_busy_i,
    output decode_pkg::dec_uop_t            ins0_o,
    output decode_pkg::dec_uop_t            ins1_o,
    output logic                            ins1_valid_o,
    output logic [`DEC_PC_W-1:0]            pc_o,
    output decode_pkg::btb_pred_t           btb_o,
    output logic                            valid_o,
    output logic                            branch_correction_flush_o,
    output logic [`DEC_PC_W-1:0]            branch_correction_pc_o
);
    import decode_pkg::*;

    logic          buf_valid;
    fetch_bundle_t buf_bundle;
    rv_instr_u     slot0_word;
    rv_instr_u     slot1_word;
    dec_uop_t      uop0, uop1;
    logic          br0, br1;
    logic          ins1_valid, correction, pending;
    logic          bundle_load;

    fetch_skid_buffer u_skid (
        .cpu_clk_i    (cpu_clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i | branch_correction_flush_o),
        .in_valid_i   (icache_valid_i),
        .in_bundle_i  (fetch_i),
        .out_busy_i   (rn_busy_i),
        .out_valid_o  (buf_valid),
        .out_bundle_o (buf_bundle),
        .busy_o       (busy_o)
    );

    // odd pc starts the pair at the upper word
    assign slot0_word  = buf_bundle.pc[0] ? buf_bundle.instr[63:32] : buf_bundle.instr[31:0];
    assign slot1_word  = buf_bundle.instr[63:32];
    assign bundle_load = buf_valid & !rn_busy_i;

    rv_slot_decoder u_dec0 (
        .instr_i           (slot0_word),
        .fetch_excp_vld_i  (buf_bundle.excp_vld),
        .fetch_excp_code_i (buf_bundle.excp_code),
        .priv_m_i          (priv_m_i),
        .tw_i              (tw_i),
        .uop_o             (uop0),
        .is_branch_o       (br0)
    );

    rv_slot_decoder u_dec1 (
        .instr_i           (slot1_word),
        .fetch_excp_vld_i  (buf_bundle.excp_vld),
        .fetch_excp_code_i (buf_bundle.excp_code),
        .priv_m_i          (priv_m_i),
        .tw_i              (tw_i),
        .uop_o             (uop1),
        .is_branch_o       (br1)
    );

    branch_check u_bchk (
        .cpu_clk_i                 (cpu_clk_i),
        .arst_n_i                  (arst_n_i),
        .flush_i                   (flush_i),
        .bundle_valid_i            (buf_valid),
        .bundle_load_i             (bundle_load),
        .pc_i                      (buf_bundle.pc),
        .btb_i                     (buf_bundle.btb),
        .slot_branch_i             ({br1, br0}),
        .icache_idle_i             (icache_idle_i),
        .rn_busy_i                 (rn_busy_i),
        .ins1_valid_o              (ins1_valid),
        .correction_o              (correction),
        .busy_pending_o            (pending),
        .branch_correction_flush_o (branch_correction_flush_o),
        .branch_correction_pc_o    (branch_correction_pc_o)
    );

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i | branch_correction_flush_o) begin
            valid_o <= 1'b0;
        end else if (!rn_busy_i) begin
            valid_o <= buf_valid & !pending & !correction;   // bubble when buffer empty
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (bundle_load) begin
            ins0_o       <= uop0;
            ins1_o       <= uop1;
            ins1_valid_o <= ins1_valid;
            pc_o         <= buf_bundle.pc;
            btb_o        <= buf_bundle.btb;
        end
    end

endmodule

`default_nettype wire

//--- branch_check.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module branch_check (
    input  wire logic                   cpu_clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   flush_i,
    input  wire logic                   bundle_valid_i,
    input  wire logic                   bundle_load_i,
    input  wire logic [`DEC_PC_W-1:0]   pc_i,
    input  wire decode_pkg::btb_pred_t  btb_i,
    input  wire logic [1:0]             slot_branch_i,
    input  wire logic                   icache_idle_i,
    input  wire logic                   rn_busy_i,
    output logic                        ins1_valid_o,
    output logic                        correction_o,
    output logic                        busy_pending_o,
    output logic                        branch_correction_flush_o,
    output logic [`DEC_PC_W-1:0]        branch_correction_pc_o
);
    logic                 taken;
    logic [1:0]           predicted;
    logic [1:0]           decoded;
    logic                 mismatch;
    logic                 capture;
    logic                 pending_q;
    logic [`DEC_PC_W-1:0] pc_q;

    assign taken = btb_i.btype[1] | btb_i.bm_pred[1];
    // slot 1 dies on an odd pc or a taken slot-0 branch leaving the pair
    assign ins1_valid_o = !pc_i[0] & !(btb_i.vld & !btb_i.idx & taken &
                                       (btb_i.target != {pc_i[`DEC_PC_W-1:1], 1'b1}));

    assign predicted = {btb_i.vld & btb_i.idx & ins1_valid_o, btb_i.vld & !btb_i.idx};
    assign decoded   = {slot_branch_i[1] & ins1_valid_o, slot_branch_i[0]};
    assign mismatch  = |(predicted & ~decoded);

    assign correction_o = bundle_valid_i & mismatch;
    assign capture      = !flush_i & !pending_q & bundle_load_i & mismatch;

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (flush_i | branch_correction_flush_o) begin
            pending_q <= 1'b0;
        end else if (capture) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (capture) begin
            pc_q <= pc_i;
        end
    end

    assign busy_pending_o            = pending_q;
    assign branch_correction_flush_o = pending_q & icache_idle_i & !flush_i & !rn_busy_i;
    assign branch_correction_pc_o    = pc_q;

endmodule

`default_nettype wire

//--- rv_slot_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "decode_defs.svh"

module rv_slot_decoder (
    input  wire decode_pkg::rv_instr_u      instr_i,
    input  wire logic                       fetch_excp_vld_i,
    input  wire logic [`DEC_EXCP_W-1:0]     fetch_excp_code_i,
    input  wire logic                       priv_m_i,   // 1 = machine mode
    input  wire logic                       tw_i,
    output decode_pkg::dec_uop_t            uop_o,
    output logic                            is_branch_o
);
    logic [4:0]           opc;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic [24:0]          sys_bits;
    logic                 is_load, is_store, is_op, is_opimm, is_lui, is_auipc;
    logic                 is_jal, is_jalr, is_branch, is_sys, is_fence, is_fencei;
    logic                 is_ecall, is_ebreak, is_mret, is_wfi, is_csr;
    logic                 op_ok, opimm_ok, sys_ok, illegal, priv_illegal;
    logic [`DEC_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opc      = instr_i.r.opcode[6:2];
    assign f3       = instr_i.r.funct3;
    assign f7       = instr_i.r.funct7;
    assign sys_bits = instr_i[31:7];

    assign is_load   = opc == `DEC_OPC_LOAD;
    assign is_store  = opc == `DEC_OPC_STORE;
    assign is_op     = opc == `DEC_OPC_OP;
    assign is_opimm  = opc == `DEC_OPC_OPIMM;
    assign is_lui    = opc == `DEC_OPC_LUI;
    assign is_auipc  = opc == `DEC_OPC_AUIPC;
    assign is_jal    = opc == `DEC_OPC_JAL;
    assign is_jalr   = (opc == `DEC_OPC_JALR) & (f3 == 3'b000);
    assign is_branch = opc == `DEC_OPC_BRANCH;
    assign is_sys    = opc == `DEC_OPC_SYSTEM;
    assign is_fence  = (opc == `DEC_OPC_MISCMEM) & (f3 == 3'b000);
    assign is_fencei = (opc == `DEC_OPC_MISCMEM) & (f3 == 3'b001);

    assign is_ecall  = is_sys & (sys_bits == 25'h0000000);
    assign is_ebreak = is_sys & (sys_bits == 25'h0002000);
    assign is_mret   = is_sys & (sys_bits == 25'h0604000);
    assign is_wfi    = is_sys & (sys_bits == 25'h020a000);
    assign is_csr    = is_sys & (f3[1:0] != 2'b00);

    // sub and sra are the only alternate encodings in rv32i
    assign op_ok    = (f7 == 7'b0000000) |
                      ((f7 == 7'b0100000) & ((f3 == 3'b000) | (f3 == 3'b101)));
    assign opimm_ok = (f3 == 3'b001) ? (f7 == 7'b0000000) :
                      (f3 == 3'b101) ? ((f7 == 7'b0000000) | (f7 == 7'b0100000)) : 1'b1;
    assign sys_ok   = is_ecall | is_ebreak | is_mret | is_wfi | is_csr;

    assign illegal = !(&instr_i.r.opcode[1:0]) |
                     !(is_lui | is_auipc | is_jal | is_jalr | is_fence | is_fencei |
                       (is_op & op_ok) | (is_opimm & opimm_ok) |
                       (is_branch & !(f3[1] & !f3[2])) |      // 010, 011 unused
                       (is_load & !(&f3[2:1])) |
                       (is_store & (f3 <= 3'b010)) |
                       sys_ok);
    assign priv_illegal = !priv_m_i & (is_mret | (is_wfi & tw_i));

    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{20{instr_i.b.imm12}}, instr_i.b.imm11, instr_i.b.imm10_5,
                    instr_i.b.imm4_1, 1'b0};
    assign imm_u = {instr_i.u.imm, 12'h000};
    assign imm_j = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12, instr_i.j.imm11,
                    instr_i.j.imm10_1, 1'b0};

    always_comb begin
        uop_o.port = !(is_jal | is_jalr | is_auipc | is_lui | is_op | is_opimm | is_branch);
        uop_o.dnagn = is_fencei | is_mret | is_wfi;
        uop_o.alu.alu_type = {is_auipc, is_lui, is_jalr, is_jal, is_op | is_opimm};
        if (is_op | is_opimm) begin
            uop_o.alu.alu_opcode = {3'b000, f7[5] & (is_op | (f3 == 3'b101)), f3};
        end else begin
            uop_o.alu.alu_opcode = {4'b0000, f3};
        end
        uop_o.alu.alu_imm = is_opimm;
        uop_o.ios.ios_type = {is_load, is_store, is_csr, is_fence, 1'b0};
        uop_o.ios.ios_opcode = f3;
        uop_o.special = {is_csr & ((instr_i.r.rs1 != '0) | f3[2]), is_mret, is_fencei, is_wfi};
        uop_o.rs1 = instr_i.r.rs1;
        uop_o.rs2 = instr_i.r.rs2;
        uop_o.dest = instr_i.r.rd;
        if (is_opimm | is_jalr | is_load | is_sys) begin
            uop_o.imm = imm_i;
        end else if (is_store) begin
            uop_o.imm = imm_s;
        end else if (is_lui | is_auipc) begin
            uop_o.imm = imm_u;
        end else if (is_jal) begin
            uop_o.imm = imm_j;
        end else if (is_branch) begin
            uop_o.imm = imm_b;
        end else begin
            uop_o.imm = '0;
        end
        uop_o.reg_props[2] = (is_op | is_opimm | is_load | is_jal | is_jalr | is_auipc |
                              is_lui | is_csr) & (instr_i.r.rd != '0);
        uop_o.reg_props[1] = !(is_ecall | is_ebreak | is_mret | is_wfi |
                               is_auipc | is_lui | is_jal);
        uop_o.reg_props[0] = is_op | is_branch | is_store;
        uop_o.excp_valid = fetch_excp_vld_i | illegal | priv_illegal | is_ecall | is_ebreak;
        if (fetch_excp_vld_i) begin
            uop_o.excp_code = fetch_excp_code_i;
        end else if (illegal | priv_illegal) begin
            uop_o.excp_code = `DEC_EXCP_ILLEGAL;
        end else if (is_ecall) begin
            uop_o.excp_code = `DEC_EXCP_ECALL_BASE | {2'b00, priv_m_i, priv_m_i};
        end else begin
            uop_o.excp_code = `DEC_EXCP_BREAK;
        end
    end

    assign is_branch_o = is_jal | is_jalr | is_branch;

endmodule

`default_nettype wire

//--- fetch_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_skid_buffer (
    input  wire logic                       cpu_clk_i,
    input  wire logic                       arst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       in_valid_i,
    input  wire decode_pkg::fetch_bundle_t  in_bundle_i,
    input  wire logic                       out_busy_i,
    output logic                            out_valid_o,
    output decode_pkg::fetch_bundle_t       out_bundle_o,
    output logic                            busy_o
);
    import decode_pkg::*;

    fetch_bundle_t skid_q;
    logic          full_q;
    logic          store;

    // capture only when the consumer stalls a bundle arriving at an empty buffer
    assign store = !full_q & in_valid_i & out_busy_i;

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (full_q) begin
            if (!out_busy_i) begin
                full_q <= 1'b0;   // drained
            end
        end else if (store) begin
            full_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (store) begin
            skid_q <= in_bundle_i;
        end
    end

    assign out_valid_o  = full_q | in_valid_i;
    assign out_bundle_o = full_q ? skid_q : in_bundle_i;  // pass-through when empty
    assign busy_o       = full_q;

endmodule

`default_nettype wire

//--- decode_pkg.sv
`default_nettype none
`include "decode_defs.svh"

package decode_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`DEC_REG_W-1:0]  rs2;
        logic [`DEC_REG_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`DEC_REG_W-1:0]  rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`DEC_REG_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`DEC_REG_W-1:0]  rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`DEC_REG_W-1:0]  rs2;
        logic [`DEC_REG_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`DEC_REG_W-1:0]  rs2;
        logic [`DEC_REG_W-1:0]  rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`DEC_REG_W-1:0]  rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`DEC_REG_W-1:0]  rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    // one instruction word, viewed in the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_instr_u;

    typedef struct packed {
        logic [1:0]             btype;     // 00 cond, 01 indirect, 10 jump, 11 ret
        logic [1:0]             bm_pred;   // bimodal counter
        logic [`DEC_PC_W-1:0]   target;
        logic                   vld;
        logic                   idx;       // predicted slot
        logic                   way;
    } btb_pred_t;

    typedef struct packed {
        logic [2*`DEC_XLEN-1:0] instr;
        logic [`DEC_PC_W-1:0]   pc;
        btb_pred_t              btb;
        logic                   excp_vld;
        logic [`DEC_EXCP_W-1:0] excp_code;
    } fetch_bundle_t;

    typedef struct packed {
        logic [4:0]             alu_type;  // auipc, lui, jalr, jal, alu
        logic [6:0]             alu_opcode;
        logic                   alu_imm;
    } alu_ctl_t;

    typedef struct packed {
        logic [4:0]             ios_type;  // load, store, csr, fence, reserved
        logic [2:0]             ios_opcode;
    } ios_ctl_t;

    typedef struct packed {
        logic                   port;      // 1 = in-order scheduler
        logic                   dnagn;
        alu_ctl_t               alu;
        ios_ctl_t               ios;
        logic [3:0]             special;   // csr write, mret, fence.i, wfi
        logic [`DEC_REG_W-1:0]  rs1;
        logic [`DEC_REG_W-1:0]  rs2;
        logic [`DEC_REG_W-1:0]  dest;
        logic [`DEC_XLEN-1:0]   imm;
        logic [2:0]             reg_props; // rd written, rs1 used, rs2 used
        logic                   excp_valid;
        logic [`DEC_EXCP_W-1:0] excp_code;
    } dec_uop_t;

endpackage

`default_nettype wire

//--- decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// datapath widths
`define DEC_XLEN    32
`define DEC_PC_W    30
`define DEC_REG_W   5
`define DEC_EXCP_W  4

// major opcodes, instruction bits [6:2]
`define DEC_OPC_LOAD     5'b00000
`define DEC_OPC_STORE    5'b01000
`define DEC_OPC_OP       5'b01100
`define DEC_OPC_OPIMM    5'b00100
`define DEC_OPC_LUI      5'b01101
`define DEC_OPC_AUIPC    5'b00101
`define DEC_OPC_JAL      5'b11011
`define DEC_OPC_JALR     5'b11001
`define DEC_OPC_BRANCH   5'b11000
`define DEC_OPC_SYSTEM   5'b11100
`define DEC_OPC_MISCMEM  5'b00011

// exception causes
`define DEC_EXCP_ILLEGAL     4'd2
`define DEC_EXCP_BREAK       4'd3
`define DEC_EXCP_ECALL_BASE  4'd8   // plus privilege level

`endif
